//--- sources.f
rtl/rv_pkg.sv
rtl/sync_fifo.sv
rtl/reg_file.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_alu_core.sv
testbench/rv_alu_core_chk.sv
testbench/tb_rv_alu_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; a $fatal gives a nonzero status
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f sources.f \
        --top-module tb_rv_alu_core -Mdir obj_dir \
    && ./obj_dir/Vtb_rv_alu_core \
    || exit 1

//--- testbench/tb_rv_alu_core.sv
`timescale 1ns/1ps

module tb_rv_alu_core import rv_pkg::*; ();

    // Idle gaps, then back to back, then long sink holds
    localparam int N_PHASE   = 120;
    localparam int N_TOTAL   = 3 * N_PHASE;
    localparam int WD_CYCLES = 64 * N_TOTAL;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            in_valid;
    logic [31:0]     in_instr;
    logic            in_credit;
    logic            out_valid;
    logic [4:0]      out_rd;
    logic [XLEN-1:0] out_value;
    logic            out_illegal;
    logic            out_credit;

    logic [15:0]     lfsr_state = 16'd95;
    logic [31:0]     model_regs [32];
    t_wb             exp_q [$];
    int              delay_q [$];
    int              sent_cnt = 0;
    int              ret_cnt = 0;
    int              rcv_cnt = 0;

    rv_alu_core u_rv_alu_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_rd      (out_rd),
        .out_value   (out_value),
        .out_illegal (out_illegal),
        .out_credit  (out_credit)
    );

    always #2 clk = ~clk;

    // Taps of x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_step()};
        return r;
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        kind = 4'(rand_bits(4));
        f3   = 3'(rand_bits(3));
        rd   = 5'(rand_bits(3));
        rs1  = 5'(rand_bits(3));
        rs2  = 5'(rand_bits(3));
        imm  = 12'(rand_bits(12));
        f7   = F7_BASE;
        if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && rand_bits(1) == 1)
            f7 = F7_ALT;
        if (kind < 4'd7)
            return {f7, rs2, rs1, f3, rd, OPC_OP};
        if (kind < 4'd14) begin
            // Shift immediates carry funct7 above shamt
            if (f3 == F3_SLL || f3 == F3_SRL_SRA)
                imm = {f7, imm[4:0]};
            return {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        if (kind == 4'd14) begin
            opc = 7'(rand_bits(7));
            if (opc == OPC_OP || opc == OPC_OP_IMM)
                opc = 7'b0110111;
            return {imm, rs1, f3, rd, opc};
        end
        if (rand_bits(1) == 1)
            return {F7_ALT, imm[4:0], rs1, F3_SLL, rd, OPC_OP_IMM};
        return {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // RV32I OP / OP-IMM semantics over the model registers
    function automatic t_wb ref_model(input logic [31:0] word);
        t_wb         rec;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic        alt;
        logic        ok;
        opc = word[6:0];
        f3  = word[14:12];
        f7  = word[31:25];
        rd  = word[11:7];
        a   = model_regs[word[19:15]];
        b   = (opc == OPC_OP) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        alt = (f7 == F7_ALT);
        ok  = 1'b1;
        if (opc != OPC_OP && opc != OPC_OP_IMM)
            ok = 1'b0;
        else if (opc == OPC_OP)
            ok = (f7 == F7_BASE) || (alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
        else if (f3 == F3_SLL)
            ok = (f7 == F7_BASE);
        else if (f3 == F3_SRL_SRA)
            ok = (f7 == F7_BASE) || alt;
        case (f3)
            F3_ADD_SUB: v = (opc == OPC_OP && alt) ? a - b : a + b;
            F3_SLL:     v = a << b[4:0];
            F3_SLT:     v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    v = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     v = a ^ b;
            F3_SRL_SRA: v = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      v = a | b;
            default:    v = a & b;
        endcase
        rec.illegal = !ok;
        rec.rd      = ok ? rd : 5'd0;
        rec.value   = ok ? v : '0;
        if (ok && rd != 5'd0)
            model_regs[rd] = v;
        return rec;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    initial begin : source
        logic [31:0] word;
        int          gap;
        int          delay;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < N_TOTAL; n++) begin
            // First words load x1..x7 with random immediates
            if (n < 7)
                word = {12'(rand_bits(12)), 5'd0, F3_ADD_SUB, 5'(n + 1), OPC_OP_IMM};
            else
                word = gen_instr();
            gap   = (n < N_PHASE) ? int'(rand_bits(2)) : 0;
            delay = int'(rand_bits(3));
            if (n >= 2 * N_PHASE && rand_bits(1) == 1)
                delay += 32;
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            do begin
                @(posedge clk);
                in_valid <= 1'b0;
            end while (sent_cnt - ret_cnt >= IN_DEPTH);
            exp_q.push_back(ref_model(word));
            delay_q.push_back(delay);
            in_valid <= 1'b1;
            in_instr <= word;
            sent_cnt++;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait (rcv_cnt == N_TOTAL);
        // Room for a stray duplicate record to show up
        repeat (60) @(posedge clk);
        if (ret_cnt != sent_cnt)
            abort_run("in_credit pulses fell short of the words sent");
        else begin
            $display("TEST PASS");
            $finish;
        end
    end

    // Sink returns one credit per record after its delay
    initial begin : sink
        int due_q [$];
        int cycle;
        out_credit = 1'b0;
        cycle      = 0;
        forever begin
            @(negedge clk);
            if (arst_n && out_valid && delay_q.size() != 0)
                due_q.push_back(cycle + delay_q.pop_front());
            @(posedge clk);
            cycle++;
            out_credit <= 1'b0;
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                out_credit <= 1'b1;
            end
        end
    end

    always @(negedge clk) begin : compare
        t_wb exp_rec;
        if (arst_n) begin
            if (in_credit) begin
                if (ret_cnt >= sent_cnt)
                    abort_run("in_credit pulsed more often than words were sent");
                ret_cnt++;
            end
            if (out_valid) begin
                if (exp_q.size() == 0)
                    abort_run("A record arrived with no instruction outstanding");
                exp_rec = exp_q.pop_front();
                check_val("out_rd", 32'(out_rd), 32'(exp_rec.rd));
                check_val("out_value", out_value, exp_rec.value);
                check_val("out_illegal", 32'(out_illegal), 32'(exp_rec.illegal));
                rcv_cnt++;
            end
        end
    end

    initial begin : watchdog
        repeat (WD_CYCLES) @(posedge clk);
        abort_run("Watchdog expired because results stopped arriving");
    end

endmodule

//--- testbench/rv_alu_core_chk.sv
`timescale 1ns/1ps

module rv_alu_core_chk import rv_pkg::*; (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    out_valid,
    input logic [OUT_CREDIT_W-1:0] credit_cnt
);

    // A record leaves only while a sink credit is held
    a_credit_held: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> $past(credit_cnt) != '0)
        else $error("out_valid raised while the credit counter was zero");

    // Sink never grants more than it can hold
    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= OUT_CREDIT_W'(OUT_CREDITS))
        else $error("credit counter above the sink capacity");

    a_idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !out_valid)
        else $error("out_valid high in the first cycle after reset");

endmodule

bind rv_result rv_alu_core_chk u_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_valid  (out_valid),
    .credit_cnt (credit_cnt)
);

//--- rtl/rv_alu_core.sv
`timescale 1ns/1ps

module rv_alu_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  logic [31:0]     in_instr,
    output logic            in_credit,
    output logic            out_valid,
    output logic [4:0]      out_rd,
    output logic [XLEN-1:0] out_value,
    output logic            out_illegal,
    input  logic            out_credit
);

    logic [31:0]     q_instr;
    logic            q_not_empty;
    logic            q_pop;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    logic            issue_valid;
    t_uop            issue_uop;
    logic [4:0]      issue_rd;
    logic [XLEN-1:0] issue_a;
    logic [XLEN-1:0] issue_b;
    logic            ex_ready;

    logic            ex1_valid;
    logic [4:0]      ex1_rd;
    logic [XLEN-1:0] ex1_value;
    logic            ex1_illegal;

    logic            result_ready;
    logic            we;
    logic [4:0]      wr_addr;
    logic [XLEN-1:0] wr_data;

    // Each word leaving the queue frees a source credit
    assign in_credit = q_pop;

    sync_fifo #(
        .payload_t (logic [31:0]),
        .DEPTH     (IN_DEPTH)
    ) u_instr_q (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (in_valid),
        .push_data (in_instr),
        .pop       (q_pop),
        .pop_data  (q_instr),
        .not_empty (q_not_empty),
        .not_full  ()
    );

    rv_decode u_decode (
        .instr       (q_instr),
        .instr_valid (q_not_empty),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_ready    (ex_ready),
        .fwd_valid   (ex1_valid && !ex1_illegal),
        .fwd_rd      (ex1_rd),
        .fwd_value   (ex1_value),
        .instr_pop   (q_pop),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .issue_rd    (issue_rd),
        .issue_a     (issue_a),
        .issue_b     (issue_b)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (we),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    rv_execute u_execute (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_uop    (issue_uop),
        .issue_rd     (issue_rd),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .result_ready (result_ready),
        .ex_ready     (ex_ready),
        .ex1_valid    (ex1_valid),
        .ex1_rd       (ex1_rd),
        .ex1_value    (ex1_value),
        .ex1_illegal  (ex1_illegal)
    );

    rv_result u_result (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex1_valid    (ex1_valid),
        .ex1_rd       (ex1_rd),
        .ex1_value    (ex1_value),
        .ex1_illegal  (ex1_illegal),
        .out_credit   (out_credit),
        .result_ready (result_ready),
        .we           (we),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .out_valid    (out_valid),
        .out_rd       (out_rd),
        .out_value    (out_value),
        .out_illegal  (out_illegal)
    );

endmodule

//--- rtl/rv_result.sv
`timescale 1ns/1ps

module rv_result import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            ex1_valid,
    input  logic [4:0]      ex1_rd,
    input  logic [XLEN-1:0] ex1_value,
    input  logic            ex1_illegal,
    input  logic            out_credit,
    output logic            result_ready,
    output logic            we,
    output logic [4:0]      wr_addr,
    output logic [XLEN-1:0] wr_data,
    output logic            out_valid,
    output logic [4:0]      out_rd,
    output logic [XLEN-1:0] out_value,
    output logic            out_illegal
);

    logic                    accept;
    logic                    send;
    logic                    wb_not_empty;
    logic                    wb_not_full;
    t_wb                     wb_in;
    t_wb                     wb_head;
    logic [OUT_CREDIT_W-1:0] credit_cnt;

    assign result_ready = wb_not_full;
    assign accept       = ex1_valid && wb_not_full;

    // Register write happens as the record is buffered
    assign we      = accept && !ex1_illegal && (ex1_rd != 5'd0);
    assign wr_addr = ex1_rd;
    assign wr_data = ex1_value;

    assign wb_in.rd      = ex1_rd;
    assign wb_in.value   = ex1_value;
    assign wb_in.illegal = ex1_illegal;

    sync_fifo #(
        .payload_t (t_wb),
        .DEPTH     (OUT_DEPTH)
    ) u_wb_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (accept),
        .push_data (wb_in),
        .pop       (send),
        .pop_data  (wb_head),
        .not_empty (wb_not_empty),
        .not_full  (wb_not_full)
    );

    // Only spend a credit the sink has granted
    assign send = wb_not_empty && (credit_cnt != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= OUT_CREDIT_W'(OUT_CREDITS);
            out_valid  <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - OUT_CREDIT_W'(send) + OUT_CREDIT_W'(out_credit);
            out_valid  <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_rd      <= wb_head.rd;
            out_value   <= wb_head.value;
            out_illegal <= wb_head.illegal;
        end
    end

endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            issue_valid,
    input  t_uop            issue_uop,
    input  logic [4:0]      issue_rd,
    input  logic [XLEN-1:0] issue_a,
    input  logic [XLEN-1:0] issue_b,
    input  logic            result_ready,
    output logic            ex_ready,
    output logic            ex1_valid,
    output logic [4:0]      ex1_rd,
    output logic [XLEN-1:0] ex1_value,
    output logic            ex1_illegal
);

    logic [XLEN-1:0] alu_out;

    always_comb begin
        case (issue_uop)
            U_ADD:   alu_out = issue_a + issue_b;
            U_SUB:   alu_out = issue_a - issue_b;
            U_SLL:   alu_out = issue_a << issue_b[4:0];
            U_SLT:   alu_out = {{(XLEN-1){1'b0}}, $signed(issue_a) < $signed(issue_b)};
            U_SLTU:  alu_out = {{(XLEN-1){1'b0}}, issue_a < issue_b};
            U_XOR:   alu_out = issue_a ^ issue_b;
            U_SRL:   alu_out = issue_a >> issue_b[4:0];
            U_SRA:   alu_out = $unsigned($signed(issue_a) >>> issue_b[4:0]);
            U_OR:    alu_out = issue_a | issue_b;
            U_AND:   alu_out = issue_a & issue_b;
            default: alu_out = '0;  // illegal records carry zero
        endcase
    end

    // ex1 may refill in the cycle it drains
    assign ex_ready = !ex1_valid || result_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            ex1_valid <= 1'b0;
        else if (ex_ready)
            ex1_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (ex_ready && issue_valid) begin
            ex1_rd      <= issue_rd;
            ex1_value   <= alu_out;
            ex1_illegal <= (issue_uop == U_ILLEGAL);
        end
    end

endmodule

//--- rtl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  logic [31:0]     instr,
    input  logic            instr_valid,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic            ex_ready,
    input  logic            fwd_valid,
    input  logic [4:0]      fwd_rd,
    input  logic [XLEN-1:0] fwd_value,
    output logic            instr_pop,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    output logic            issue_valid,
    output t_uop            issue_uop,
    output logic [4:0]      issue_rd,
    output logic [XLEN-1:0] issue_a,
    output logic [XLEN-1:0] issue_b
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    t_uop            uop;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Shift immediates find shamt in the low immediate bits
    assign imm      = {{(XLEN-12){instr[31]}}, instr[31:20]};

    always_comb begin
        uop     = U_ILLEGAL;
        use_imm = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: uop = U_ADD;
                        F3_SLL:     uop = U_SLL;
                        F3_SLT:     uop = U_SLT;
                        F3_SLTU:    uop = U_SLTU;
                        F3_XOR:     uop = U_XOR;
                        F3_SRL_SRA: uop = U_SRL;
                        F3_OR:      uop = U_OR;
                        default:    uop = U_AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == F3_ADD_SUB)
                        uop = U_SUB;
                    else if (funct3 == F3_SRL_SRA)
                        uop = U_SRA;
                end
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    F3_ADD_SUB: uop = U_ADD;
                    F3_SLT:     uop = U_SLT;
                    F3_SLTU:    uop = U_SLTU;
                    F3_XOR:     uop = U_XOR;
                    F3_OR:      uop = U_OR;
                    F3_AND:     uop = U_AND;
                    F3_SLL:     if (funct7 == F7_BASE) uop = U_SLL;
                    default: begin
                        // srli / srai differ only in funct7
                        if (funct7 == F7_BASE)
                            uop = U_SRL;
                        else if (funct7 == F7_ALT)
                            uop = U_SRA;
                    end
                endcase
            end
            default: ;
        endcase
    end

    // Bypass from ex1 when its destination matches
    assign rs1_val = (fwd_valid && fwd_rd != 5'd0 && fwd_rd == rs1_addr) ? fwd_value : rs1_data;
    assign rs2_val = (fwd_valid && fwd_rd != 5'd0 && fwd_rd == rs2_addr) ? fwd_value : rs2_data;

    assign instr_pop   = instr_valid && ex_ready;
    assign issue_valid = instr_pop;
    assign issue_uop   = uop;
    assign issue_rd    = (uop == U_ILLEGAL) ? 5'd0 : instr[11:7];
    assign issue_a     = rs1_val;
    assign issue_b     = use_imm ? imm : rs2_val;

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    input  logic            we,
    input  logic [4:0]      wr_addr,
    input  logic [XLEN-1:0] wr_data
);

    logic [XLEN-1:0] regs [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     not_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    assign pop_data  = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign not_full  = (count != CNT_W'(DEPTH));

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Instruction queue depth and the source's initial credit count
    localparam int IN_DEPTH = 4;

    // Writeback buffering and sink credits
    localparam int OUT_DEPTH = 2;
    localparam int OUT_CREDITS = 2;
    localparam int OUT_CREDIT_W = $clog2(OUT_CREDITS + 1);

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 codes
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        U_ADD, U_SUB, U_SLL, U_SLT, U_SLTU,
        U_XOR, U_SRL, U_SRA, U_OR, U_AND,
        U_ILLEGAL
    } t_uop;

    // One record per retired instruction
    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
        logic            illegal;
    } t_wb;

endpackage
